// File: flist.f
verilog/ddr4_ctrl_pkg.sv
verilog/sdram_bank_state.sv
verilog/read_return_queue.sv
verilog/ddr4_sdram_controller.sv
verification/dimm_model.sv
verification/ddr4_tb.sv

// File: verification/ddr4_tb.sv
`timescale 1ns/1ps

module ddr4_tb;

    localparam int NUM_REQS    = 200;
    localparam int CYCLE_LIMIT = NUM_REQS * 24 + 500;  // worst case per request plus drain
    localparam int ADDR_SPACE  = 1 << ddr4_ctrl_pkg::PADDR_BITS;
    localparam int ROW_LSB     = ddr4_ctrl_pkg::COL_BITS;
    localparam int BANK_LSB    = ddr4_ctrl_pkg::COL_BITS + ddr4_ctrl_pkg::ROW_BITS;
    localparam int DW          = ddr4_ctrl_pkg::DATA_BITS;

    logic                                 clk_in;
    logic                                 rst_N_in;
    logic                                 req_valid;
    logic                                 req_write;
    logic [ddr4_ctrl_pkg::PADDR_BITS-1:0] req_addr;
    logic [DW-1:0]                        req_wdata;
    logic                                 req_ready;
    logic                                 rsp_valid;
    logic [DW-1:0]                        rsp_data;
    logic                                 cs_n;
    logic                                 act_n;
    logic [2:0]                           cmd_code;
    ddr4_ctrl_pkg::dram_addr_t            dram_addr;
    logic [ddr4_ctrl_pkg::BG_BITS-1:0]    bg;
    logic [ddr4_ctrl_pkg::BA_BITS-1:0]    ba;
    logic [DW-1:0]                        dq_out;
    logic                                 dq_oe;
    logic [DW-1:0]                        dq_in;

    // reference model
    logic [DW-1:0] ref_mem [ADDR_SPACE];
    logic [DW-1:0] exp_data_q [$];   // expected read words in acceptance order
    int            exp_cycle_q [$];  // cycle each response is due
    logic [DW-1:0] exp_data;
    int            exp_cycle;

    // bank history seen on the dram side
    logic [ddr4_ctrl_pkg::BANKS-1:0] act_seen  = '0;
    logic [ddr4_ctrl_pkg::BANKS-1:0] pre_seen  = '0;
    logic [ddr4_ctrl_pkg::BANKS-1:0] pre_after = '0;  // precharge since last activate
    logic [ddr4_ctrl_pkg::ROW_BITS-1:0] act_row [ddr4_ctrl_pkg::BANKS];
    int            act_cyc [ddr4_ctrl_pkg::BANKS];
    int            pre_cyc [ddr4_ctrl_pkg::BANKS];
    logic [3:0]    cmd_bank;

    // request accepted on the last edge, its column command is due now
    logic          pend_valid = 1'b0;
    logic          pend_write;
    logic [3:0]    pend_bank;
    logic [7:0]    pend_row;
    logic [3:0]    pend_col;
    logic [DW-1:0] pend_wdata;

    int            tb_cycle     = 0;
    int            watchdog     = 0;
    int            rd_accepted  = 0;
    int            rsp_count    = 0;
    int            err_mismatch = 0;
    int            err_other    = 0;
    logic          rst_prev     = 1'b1;

    // stimulus draws
    logic [31:0]   seed;
    logic          pick_write;
    logic [3:0]    pick_bank;
    logic [7:0]    pick_row;
    logic [3:0]    pick_col;
    logic [DW-1:0] pick_data;

    ddr4_sdram_controller dut (
        .clk_in    (clk_in),
        .rst_N_in  (rst_N_in),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .cs_n      (cs_n),
        .act_n     (act_n),
        .cmd_code  (cmd_code),
        .dram_addr (dram_addr),
        .bg        (bg),
        .ba        (ba),
        .dq_out    (dq_out),
        .dq_oe     (dq_oe),
        .dq_in     (dq_in)
    );

    dimm_model u_dimm (
        .clk_in    (clk_in),
        .cs_n      (cs_n),
        .act_n     (act_n),
        .cmd_code  (cmd_code),
        .dram_addr (dram_addr),
        .bg        (bg),
        .ba        (ba),
        .dq_out    (dq_out),
        .dq_oe     (dq_oe),
        .dq_in     (dq_in)
    );

    always #50 clk_in = !clk_in;  // 100 ns period

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            err_mismatch++;
        end
    endtask

    task automatic flag_error(input string what);
        $display("Error at %0t ns: %s", $time, what);
        err_other++;
    endtask

    // watchdog, ends a hung run
    always @(posedge clk_in) begin
        watchdog++;
        if (watchdog >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // monitor and reference model, all samples are pre edge values
    always @(posedge clk_in) begin
        cmd_bank = {bg, ba};
        if (rst_N_in || rst_prev) begin  // during reset and first cycle after
            check_value(cs_n, 1'b1, "cs_n in reset");
            check_value(act_n, 1'b1, "act_n in reset");
            check_value(cmd_code, ddr4_ctrl_pkg::CMD_NOP, "cmd_code in reset");
            check_value(dq_oe, 1'b0, "dq_oe in reset");
            check_value(rsp_valid, 1'b0, "rsp_valid in reset");
            check_value(req_ready, 1'b0, "req_ready in reset");
        end
        if (!rst_N_in) begin
            check_value(act_n, !(!cs_n && cmd_code == ddr4_ctrl_pkg::CMD_ACT), "act_n");
            check_value(dq_oe, !cs_n && cmd_code == ddr4_ctrl_pkg::CMD_WR, "dq_oe");
            if (pend_valid) begin  // column command must follow acceptance
                check_value(cs_n, 1'b0, "cs_n with column command");
                check_value(cmd_code, pend_write ? ddr4_ctrl_pkg::CMD_WR :
                            ddr4_ctrl_pkg::CMD_RD, "column command code");
            end
            if (!cs_n && cmd_code == ddr4_ctrl_pkg::CMD_ACT) begin
                if (act_seen[cmd_bank] && !pre_after[cmd_bank]) begin
                    flag_error($sformatf("activate to bank %0d with a row open", cmd_bank));
                end
                if (pre_seen[cmd_bank] &&
                    tb_cycle - pre_cyc[cmd_bank] < ddr4_ctrl_pkg::PRECHARGE_LATENCY) begin
                    flag_error($sformatf("activate too soon after precharge, bank %0d",
                                         cmd_bank));
                end
                act_seen[cmd_bank]  = 1'b1;
                pre_after[cmd_bank] = 1'b0;
                act_row[cmd_bank]   = dram_addr.row_view.row;
                act_cyc[cmd_bank]   = tb_cycle;
            end else if (!cs_n && cmd_code == ddr4_ctrl_pkg::CMD_PRE) begin
                if (act_seen[cmd_bank] &&
                    tb_cycle - act_cyc[cmd_bank] < ddr4_ctrl_pkg::ACTIVATION_LATENCY) begin
                    flag_error($sformatf("precharge too soon after activate, bank %0d",
                                         cmd_bank));
                end
                pre_seen[cmd_bank]  = 1'b1;
                pre_after[cmd_bank] = 1'b1;
                pre_cyc[cmd_bank]   = tb_cycle;
            end else if (!cs_n && (cmd_code == ddr4_ctrl_pkg::CMD_RD ||
                                   cmd_code == ddr4_ctrl_pkg::CMD_WR)) begin
                if (!act_seen[cmd_bank] || pre_after[cmd_bank]) begin
                    flag_error($sformatf("column command to closed bank %0d", cmd_bank));
                end else if (tb_cycle - act_cyc[cmd_bank] < ddr4_ctrl_pkg::ACTIVATION_LATENCY) begin
                    flag_error($sformatf("column command too soon after activate, bank %0d",
                                         cmd_bank));
                end
                if (!pend_valid) begin
                    flag_error("column command without an accepted request");
                end else begin
                    check_value(cmd_bank, pend_bank, "column command bank");
                    check_value(act_row[cmd_bank], pend_row, "column command row");
                    check_value(dram_addr.col_view.col, pend_col, "column command column");
                    check_value(dram_addr.col_view.rd, !pend_write, "read flag");
                    if (pend_write) begin
                        check_value(dq_out, pend_wdata, "write data on dq_out");
                    end
                end
            end
            if (rsp_valid) begin
                rsp_count++;
                if (exp_data_q.size() == 0) begin
                    flag_error("response with no read outstanding");
                end else begin
                    exp_data  = exp_data_q.pop_front();
                    exp_cycle = exp_cycle_q.pop_front();
                    check_value(rsp_data, exp_data, "read data");
                    check_value(tb_cycle, exp_cycle, "response cycle");
                end
            end
        end
        // handshake on this edge
        pend_valid = 1'b0;
        if (!rst_N_in && req_valid && req_ready) begin
            pend_valid = 1'b1;
            pend_write = req_write;
            pend_bank  = req_addr[BANK_LSB +: 4];
            pend_row   = req_addr[ROW_LSB +: 8];
            pend_col   = req_addr[3:0];
            pend_wdata = req_wdata;
            if (req_write) begin
                ref_mem[req_addr] = req_wdata;
            end else begin
                exp_data_q.push_back(ref_mem[req_addr]);
                exp_cycle_q.push_back(tb_cycle + ddr4_ctrl_pkg::CAS_LATENCY + 2);
                rd_accepted++;
            end
        end
        rst_prev = rst_N_in;
        tb_cycle++;
    end

    initial begin
        clk_in    = 1'b0;
        rst_N_in  <= 1'b1;  // reset asserted
        req_valid <= 1'b0;
        req_write <= 1'b0;
        req_addr  <= '0;
        req_wdata <= '0;
        seed      = 32'd77;
        for (int a = 0; a < ADDR_SPACE; a++) begin
            ref_mem[a] = '0;
        end
        repeat (2) @(posedge clk_in);
        rst_N_in <= 1'b0;
        @(posedge clk_in);  // idle cycle right after reset
        for (int i = 0; i < NUM_REQS; i++) begin
            seed       = lcg_step(seed);
            pick_write = seed[31];
            pick_bank  = seed[27:24];
            pick_row   = seed[22] ? 8'h3c : 8'hc3;  // two rows per bank
            pick_col   = seed[19:16];
            seed       = lcg_step(seed);
            pick_data[63:32] = seed;
            seed       = lcg_step(seed);
            pick_data[31:0]  = seed;
            req_valid <= 1'b1;
            req_write <= pick_write;
            req_addr  <= {pick_bank, pick_row, pick_col};
            req_wdata <= pick_data;
            @(posedge clk_in);
            while (!req_ready) begin  // hold until the controller accepts
                @(posedge clk_in);
            end
        end
        req_valid <= 1'b0;
        @(negedge clk_in);
        while (rsp_count < rd_accepted) begin
            @(negedge clk_in);
        end
        repeat (ddr4_ctrl_pkg::CAS_LATENCY + 4) @(negedge clk_in);  // catch stray responses
        check_value(rsp_count, rd_accepted, "response count");
        $display("errors: %0d mismatches, %0d other failures", err_mismatch, err_other);
        if (err_mismatch == 0 && err_other == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verification/dimm_model.sv
`timescale 1ns/1ps

module dimm_model (
    input  logic                                clk_in,
    input  logic                                cs_n,
    input  logic                                act_n,
    input  logic [2:0]                          cmd_code,
    input  ddr4_ctrl_pkg::dram_addr_t           dram_addr,
    input  logic [ddr4_ctrl_pkg::BG_BITS-1:0]   bg,
    input  logic [ddr4_ctrl_pkg::BA_BITS-1:0]   ba,
    input  logic [ddr4_ctrl_pkg::DATA_BITS-1:0] dq_out,
    input  logic                                dq_oe,
    output logic [ddr4_ctrl_pkg::DATA_BITS-1:0] dq_in
);

    localparam int CELL_BITS = ddr4_ctrl_pkg::BG_BITS + ddr4_ctrl_pkg::BA_BITS +
                               ddr4_ctrl_pkg::ROW_BITS + ddr4_ctrl_pkg::COL_BITS;
    localparam int CELLS     = 1 << CELL_BITS;
    localparam int CL        = ddr4_ctrl_pkg::CAS_LATENCY;

    logic [ddr4_ctrl_pkg::DATA_BITS-1:0] cells [CELLS];                 // bank, row, column
    logic [ddr4_ctrl_pkg::ROW_BITS-1:0]  row_buf [ddr4_ctrl_pkg::BANKS]; // row opened per bank
    logic [ddr4_ctrl_pkg::DATA_BITS-1:0] rd_pipe [CL];                  // read data in flight
    logic [CELL_BITS-1:0]                cell_idx;
    logic                                rd_cmd;
    logic                                wr_cmd;

    // column commands use the row left open by the last activate
    assign cell_idx = {bg, ba, row_buf[{bg, ba}], dram_addr.col_view.col};
    assign rd_cmd   = !cs_n && act_n && (cmd_code == ddr4_ctrl_pkg::CMD_RD);
    assign wr_cmd   = !cs_n && act_n && (cmd_code == ddr4_ctrl_pkg::CMD_WR) && dq_oe;
    assign dq_in    = rd_pipe[CL-1];  // last stage is on the bus

    initial begin
        for (int i = 0; i < CELLS; i++) begin
            cells[i] = '0;  // never written reads back as zero
        end
    end

    always @(posedge clk_in) begin
        if (!cs_n && !act_n) begin
            row_buf[{bg, ba}] <= dram_addr.row_view.row;  // activate opens the row
        end
        if (wr_cmd) begin
            cells[cell_idx] <= dq_out;
        end
        // command seen here, data driven CL cycles after it appeared
        rd_pipe[0] <= rd_cmd ? cells[cell_idx] : '0;
        for (int k = 1; k < CL; k++) begin
            rd_pipe[k] <= rd_pipe[k-1];
        end
    end

endmodule

// File: verilog/ddr4_ctrl_pkg.sv
package ddr4_ctrl_pkg;

    // timing in controller clock cycles
    localparam int CAS_LATENCY        = 6;  // read command to data on dq
    localparam int ACTIVATION_LATENCY = 4;  // bank busy after an activate
    localparam int PRECHARGE_LATENCY  = 3;  // bank busy after a precharge

    // geometry of the single rank
    localparam int ROW_BITS       = 8;
    localparam int COL_BITS       = 4;
    localparam int BG_BITS        = 2;  // bank group select
    localparam int BA_BITS        = 2;  // bank within group
    localparam int BANKS          = 1 << (BG_BITS + BA_BITS);  // 16 banks
    localparam int PADDR_BITS     = BG_BITS + BA_BITS + ROW_BITS + COL_BITS;
    localparam int DATA_BITS      = 64;
    localparam int DRAM_ADDR_BITS = 17;

    // outstanding read tracking
    localparam int QUEUE_DEPTH = 8;
    localparam int CYCLE_BITS  = 16;  // free running counter and due stamps

    // command encodings on cmd_code
    localparam logic [2:0] CMD_RD  = 3'b000;
    localparam logic [2:0] CMD_WR  = 3'b001;
    localparam logic [2:0] CMD_ACT = 3'b010;
    localparam logic [2:0] CMD_PRE = 3'b011;
    localparam logic [2:0] CMD_NOP = 3'b111;  // also what cs_n high implies

    // address word as seen with an activate
    typedef struct packed {
        logic [DRAM_ADDR_BITS-ROW_BITS-1:0] pad;  // always zero
        logic [ROW_BITS-1:0]                row;
    } row_view_t;

    // address word as seen with rd, wr and pre
    typedef struct packed {
        logic                               pre_all;   // precharge every bank
        logic                               auto_pre;  // close row after access
        logic                               rd;        // read flag
        logic [DRAM_ADDR_BITS-4-COL_BITS:0] pad;       // always zero
        logic [COL_BITS-1:0]                col;
    } col_view_t;

    typedef union packed {
        row_view_t row_view;
        col_view_t col_view;
    } dram_addr_t;

endpackage

// File: verilog/ddr4_sdram_controller.sv
`timescale 1ns/1ps

module ddr4_sdram_controller (
    input  logic                                 clk_in,
    input  logic                                 rst_N_in,
    // host request channel
    input  logic                                 req_valid,
    input  logic                                 req_write,
    input  logic [ddr4_ctrl_pkg::PADDR_BITS-1:0] req_addr,
    input  logic [ddr4_ctrl_pkg::DATA_BITS-1:0]  req_wdata,
    output logic                                 req_ready,
    // host response channel with no stall
    output logic                                 rsp_valid,
    output logic [ddr4_ctrl_pkg::DATA_BITS-1:0]  rsp_data,
    // dimm command and address
    output logic                                 cs_n,
    output logic                                 act_n,
    output logic [2:0]                           cmd_code,
    output ddr4_ctrl_pkg::dram_addr_t            dram_addr,
    output logic [ddr4_ctrl_pkg::BG_BITS-1:0]    bg,
    output logic [ddr4_ctrl_pkg::BA_BITS-1:0]    ba,
    // dimm data with the tristate in the pad ring
    output logic [ddr4_ctrl_pkg::DATA_BITS-1:0]  dq_out,
    output logic                                 dq_oe,
    input  logic [ddr4_ctrl_pkg::DATA_BITS-1:0]  dq_in
);

    localparam int IDX_BITS = ddr4_ctrl_pkg::BG_BITS + ddr4_ctrl_pkg::BA_BITS;

    localparam logic [ddr4_ctrl_pkg::CYCLE_BITS-1:0] CYC_ONE = ddr4_ctrl_pkg::CYCLE_BITS'(1);

    // read data is sampled one cycle after the dimm starts driving it
    localparam logic [ddr4_ctrl_pkg::CYCLE_BITS-1:0] RD_DELAY =
        ddr4_ctrl_pkg::CYCLE_BITS'(ddr4_ctrl_pkg::CAS_LATENCY + 1);

    // request address fields
    logic [ddr4_ctrl_pkg::BG_BITS-1:0]  req_bg;
    logic [ddr4_ctrl_pkg::BA_BITS-1:0]  req_ba;
    logic [ddr4_ctrl_pkg::ROW_BITS-1:0] req_row;
    logic [ddr4_ctrl_pkg::COL_BITS-1:0] req_col;
    logic [IDX_BITS-1:0]                bank_idx;  // flat bank number

    // bank tracker
    logic [ddr4_ctrl_pkg::BANKS-1:0]                              bank_act;
    logic [ddr4_ctrl_pkg::BANKS-1:0]                              bank_pre;
    logic [ddr4_ctrl_pkg::BANKS-1:0][ddr4_ctrl_pkg::ROW_BITS-1:0] open_row;
    logic [ddr4_ctrl_pkg::BANKS-1:0]                              bank_open;
    logic [ddr4_ctrl_pkg::BANKS-1:0]                              blocked;

    // read return tracking
    logic                                 rd_enqueue;
    logic [ddr4_ctrl_pkg::CYCLE_BITS-1:0] rd_due_stamp;
    logic [ddr4_ctrl_pkg::CYCLE_BITS-1:0] cycle_count;
    logic                                 rd_due;
    logic                                 q_full;
    logic                                 capture;

    // decision for this cycle
    logic                      row_hit;
    logic                      col_issue;  // column command goes out
    logic                      wr_issue;
    logic [2:0]                next_cmd;
    ddr4_ctrl_pkg::dram_addr_t next_addr;

    // bank group on top, then bank, row, column
    assign req_col  = req_addr[ddr4_ctrl_pkg::COL_BITS-1:0];
    assign req_row  = req_addr[ddr4_ctrl_pkg::COL_BITS +: ddr4_ctrl_pkg::ROW_BITS];
    assign req_ba   = req_addr[ddr4_ctrl_pkg::COL_BITS + ddr4_ctrl_pkg::ROW_BITS +:
                               ddr4_ctrl_pkg::BA_BITS];
    assign req_bg   = req_addr[ddr4_ctrl_pkg::PADDR_BITS-1 -: ddr4_ctrl_pkg::BG_BITS];
    assign bank_idx = {req_bg, req_ba};

    sdram_bank_state u_bank_state (
        .clk_in      (clk_in),
        .rst_N_in    (rst_N_in),
        .activate    (bank_act),
        .precharge   (bank_pre),
        .row_address (req_row),
        .open_row    (open_row),
        .bank_open   (bank_open),
        .blocked     (blocked)
    );

    read_return_queue u_rd_queue (
        .clk_in      (clk_in),
        .rst_N_in    (rst_N_in),
        .enqueue     (rd_enqueue),
        .due_stamp   (rd_due_stamp),
        .cycle_count (cycle_count),
        .due         (rd_due),
        .empty       (),
        .full        (q_full)
    );

    // free running cycle count for read due stamps
    always_ff @(posedge clk_in or posedge rst_N_in) begin
        if (rst_N_in) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + CYC_ONE;  // wraps and due compare is equality only
        end
    end

    assign row_hit      = bank_open[bank_idx] && (open_row[bank_idx] == req_row);
    assign rd_due_stamp = cycle_count + RD_DELAY;

    // pick one command for the presented request
    always_comb begin
        next_cmd   = ddr4_ctrl_pkg::CMD_NOP;
        next_addr  = '0;
        bank_act   = '0;
        bank_pre   = '0;
        col_issue  = 1'b0;
        wr_issue   = 1'b0;
        rd_enqueue = 1'b0;
        if (req_valid && !blocked[bank_idx]) begin
            if (row_hit) begin
                // reads also need a free slot in the return queue
                if (req_write || !q_full) begin
                    col_issue                = 1'b1;
                    wr_issue                 = req_write;
                    rd_enqueue               = !req_write;
                    next_cmd                 = req_write ? ddr4_ctrl_pkg::CMD_WR :
                                                           ddr4_ctrl_pkg::CMD_RD;
                    next_addr.col_view.rd    = !req_write;
                    next_addr.col_view.col   = req_col;  // no auto precharge
                end
            end else if (bank_open[bank_idx]) begin
                // row conflict so close the current row
                next_cmd           = ddr4_ctrl_pkg::CMD_PRE;
                bank_pre[bank_idx] = 1'b1;  // flags stay clear for single bank
            end else begin
                // bank idle so open the wanted row
                next_cmd               = ddr4_ctrl_pkg::CMD_ACT;
                bank_act[bank_idx]     = 1'b1;
                next_addr.row_view.row = req_row;
            end
        end
    end

    assign req_ready = col_issue;  // accept only with the column command

    // head entry is due and its data is on dq_in now
    assign capture = rd_due;

    // control outputs land one cycle after the decision
    always_ff @(posedge clk_in or posedge rst_N_in) begin
        if (rst_N_in) begin
            cs_n      <= 1'b1;
            act_n     <= 1'b1;
            cmd_code  <= ddr4_ctrl_pkg::CMD_NOP;
            dq_oe     <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            cs_n      <= (next_cmd == ddr4_ctrl_pkg::CMD_NOP);
            act_n     <= (next_cmd != ddr4_ctrl_pkg::CMD_ACT);  // low for activate only
            cmd_code  <= next_cmd;
            dq_oe     <= wr_issue;  // data rides with the write command
            rsp_valid <= capture;   // single cycle pulse per read
        end
    end

    // payload outputs
    always_ff @(posedge clk_in) begin
        dram_addr <= next_addr;
        bg        <= req_bg;
        ba        <= req_ba;
        if (wr_issue) begin
            dq_out <= req_wdata;
        end
        if (capture) begin
            rsp_data <= dq_in;
        end
    end

endmodule

// File: verilog/read_return_queue.sv
`timescale 1ns/1ps

module read_return_queue (
    input  logic                                clk_in,
    input  logic                                rst_N_in,
    input  logic                                enqueue,
    input  logic [ddr4_ctrl_pkg::CYCLE_BITS-1:0] due_stamp,
    input  logic [ddr4_ctrl_pkg::CYCLE_BITS-1:0] cycle_count,
    output logic                                due,
    output logic                                empty,
    output logic                                full
);

    localparam int PTR_BITS = $clog2(ddr4_ctrl_pkg::QUEUE_DEPTH);
    localparam int OCC_BITS = $clog2(ddr4_ctrl_pkg::QUEUE_DEPTH + 1);

    localparam logic [PTR_BITS-1:0] PTR_ONE   = PTR_BITS'(1);
    localparam logic [OCC_BITS-1:0] OCC_ONE   = OCC_BITS'(1);
    localparam logic [OCC_BITS-1:0] OCC_LIMIT = OCC_BITS'(ddr4_ctrl_pkg::QUEUE_DEPTH);

    // stamp storage, no reset needed
    logic [ddr4_ctrl_pkg::CYCLE_BITS-1:0] stamps [ddr4_ctrl_pkg::QUEUE_DEPTH];

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [OCC_BITS-1:0] occupancy;
    logic                push;
    logic                pop;

    assign empty = (occupancy == '0);
    assign full  = (occupancy == OCC_LIMIT);

    // head data comes back on this edge
    assign due = !empty && (stamps[rd_ptr] == cycle_count);

    assign push = enqueue && !full;  // controller never pushes when full
    assign pop  = due;               // head retires as it is captured

    always_ff @(posedge clk_in) begin
        if (push) begin
            stamps[wr_ptr] <= due_stamp;
        end
    end

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk_in or posedge rst_N_in) begin
        if (rst_N_in) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + PTR_ONE;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + PTR_ONE;
            end
            // simultaneous push and pop leaves the count alone
            case ({push, pop})
                2'b10:   occupancy <= occupancy + OCC_ONE;
                2'b01:   occupancy <= occupancy - OCC_ONE;
                default: occupancy <= occupancy;
            endcase
        end
    end

endmodule

// File: verilog/sdram_bank_state.sv
`timescale 1ns/1ps

module sdram_bank_state (
    input  logic                                                          clk_in,
    input  logic                                                          rst_N_in,
    input  logic [ddr4_ctrl_pkg::BANKS-1:0]                               activate,
    input  logic [ddr4_ctrl_pkg::BANKS-1:0]                               precharge,
    input  logic [ddr4_ctrl_pkg::ROW_BITS-1:0]                            row_address,
    output logic [ddr4_ctrl_pkg::BANKS-1:0][ddr4_ctrl_pkg::ROW_BITS-1:0]  open_row,
    output logic [ddr4_ctrl_pkg::BANKS-1:0]                               bank_open,
    output logic [ddr4_ctrl_pkg::BANKS-1:0]                               blocked
);

    // counter must hold the longer of the two latencies
    localparam int MAX_LAT  = (ddr4_ctrl_pkg::ACTIVATION_LATENCY >
                               ddr4_ctrl_pkg::PRECHARGE_LATENCY) ?
                              ddr4_ctrl_pkg::ACTIVATION_LATENCY :
                              ddr4_ctrl_pkg::PRECHARGE_LATENCY;
    localparam int CNT_BITS = $clog2(MAX_LAT + 1);

    localparam logic [CNT_BITS-1:0] ACT_LOAD = CNT_BITS'(ddr4_ctrl_pkg::ACTIVATION_LATENCY);
    localparam logic [CNT_BITS-1:0] PRE_LOAD = CNT_BITS'(ddr4_ctrl_pkg::PRECHARGE_LATENCY);
    localparam logic [CNT_BITS-1:0] CNT_LAST = CNT_BITS'(1);

    logic [ddr4_ctrl_pkg::BANKS-1:0][CNT_BITS-1:0] busy_cnt;  // cycles left busy
    logic [ddr4_ctrl_pkg::BANKS-1:0]               opening;   // activate in flight

    // per bank busy counter and open flag
    always_ff @(posedge clk_in or posedge rst_N_in) begin
        if (rst_N_in) begin
            busy_cnt  <= '0;
            opening   <= '0;
            bank_open <= '0;  // everything closed
        end else begin
            for (int b = 0; b < ddr4_ctrl_pkg::BANKS; b++) begin
                if (activate[b]) begin
                    busy_cnt[b]  <= ACT_LOAD;
                    opening[b]   <= 1'b1;
                    bank_open[b] <= 1'b0;  // not usable until tRCD runs out
                end else if (precharge[b]) begin
                    busy_cnt[b]  <= PRE_LOAD;
                    opening[b]   <= 1'b0;
                    bank_open[b] <= 1'b0;  // row buffer gone right away
                end else if (busy_cnt[b] != '0) begin
                    busy_cnt[b] <= busy_cnt[b] - CNT_LAST;
                    // last busy cycle of an activate
                    if (busy_cnt[b] == CNT_LAST && opening[b]) begin
                        bank_open[b] <= 1'b1;
                        opening[b]   <= 1'b0;
                    end
                end
            end
        end
    end

    // row captured with the activate, only meaningful while open
    always_ff @(posedge clk_in) begin
        for (int b = 0; b < ddr4_ctrl_pkg::BANKS; b++) begin
            if (activate[b]) begin
                open_row[b] <= row_address;
            end
        end
    end

    always_comb begin
        for (int b = 0; b < ddr4_ctrl_pkg::BANKS; b++) begin
            blocked[b] = (busy_cnt[b] != '0);  // no command while counting
        end
    end

endmodule
